// File: Makefile
# Verilator lint and simulation of the posit multiplier.
# Override on the command line, e.g. make sim N=16 ES=2

N         ?= 8
ES        ?= 1
# LFSR seed in decimal, 10693 is 0x29c5.
SEED      ?= 10693
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

RTL_SRCS := posit_fmt_pkg.sv posit_round_pkg.sv posit_decode.sv posit_mul_core.sv \
            unpack_exponent.sv compute_rouding.sv pack_fields.sv posit_encode.sv \
            posit_mul_top.sv
PARAMS   := -GN=$(N) -GES=$(ES)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall +incdir+. $(PARAMS) --top-module posit_mul_top $(RTL_SRCS)

build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f tb.f $(PARAMS) -GSEED=$(SEED) \
	    --top-module tb_posit_mul --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/Vtb_posit_mul | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compute_rouding.sv
// Round and sticky bit logic for the posit packer, taken from the bits the packed word drops.
`timescale 1ns/10ps
`include "posit_consts.svh"

module compute_rouding #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic signed [`MANT_LEN_SIZE-1:0] frac_len,
    input  logic [`FRAC_FULL_SIZE-1:0]       frac_full,
    input  logic [`S+1:0]                    frac_len_diff,
    input  logic signed [`K_SIZE-1:0]        k,
    input  logic [`EXP_SIZE-1:0]             exp,
    input  logic                             frac_truncated,
    output logic                             round_bit,
    output logic                             sticky_bit
);
    localparam int FFW = `FRAC_FULL_SIZE;
    localparam int EW  = `EXP_SIZE;
    localparam int KW  = `K_SIZE;

    int rpos;
    int exp_cut;

    assign rpos    = int'(frac_len_diff) - 1;  // First dropped fraction bit.
    assign exp_cut = -int'(frac_len);          // Exponent bits pushed out.

    always_comb begin
        // Whole exponent gone, so the regime terminator is next.
        round_bit  = k[KW-1];
        sticky_bit = frac_truncated | (|frac_full) | (|exp);
        if (frac_len >= 0) begin
            round_bit  = frac_full[rpos];
            sticky_bit = frac_truncated | (|(frac_full << (FFW - rpos)));
        end else if (exp_cut <= ES) begin
            round_bit  = exp[exp_cut-1];
            sticky_bit = frac_truncated | (|frac_full) | (|(exp << (EW - exp_cut + 1)));
        end
    end

endmodule

// File: pack_fields.sv
// Posit field packer; sizes regime, exponent and fraction for an N-bit word and flags rounding.
`timescale 1ns/10ps
`include "posit_consts.svh"

module pack_fields #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic [`FRAC_FULL_SIZE-1:0] frac_full,
    input  logic signed [`TE_SIZE-1:0] total_exp,
    input  logic                       frac_truncated,
    output logic signed [`K_SIZE-1:0]  k,
    output logic [`EXP_SIZE-1:0]       next_exp,
    output logic [`MANT_SIZE-1:0]      frac,
    output logic                       round_bit,
    output logic                       sticky_bit,
    output logic                       k_is_oob,
    output logic                       non_zero_frac_field_size
);
    import posit_fmt_pkg::*;

    localparam int KW  = `K_SIZE;
    localparam int RLW = `REG_LEN_SIZE;
    localparam int MLW = `MANT_LEN_SIZE;
    localparam int FFW = `FRAC_FULL_SIZE;
    localparam int MW  = `MANT_SIZE;
    localparam int EW  = `EXP_SIZE;
    localparam int DW  = `S + 2;
    localparam logic signed [KW-1:0] K_MAX = KW'(N - 2);

    logic signed [KW-1:0]  k_unpacked;
    logic [EW-1:0]         exp_unpacked;
    logic signed [KW-1:0]  regime_k;
    logic signed [RLW-1:0] reg_len;
    logic signed [MLW-1:0] frac_len;
    logic [DW-1:0]         frac_len_diff;
    int                    es_drop;

    unpack_exponent #(.N(N), .ES(ES)) unpack_exponent_inst (
        .total_exp(total_exp),
        .k        (k_unpacked),
        .exp      (exp_unpacked)
    );

    assign regime_k = (k_unpacked > K_MAX)  ? K_MAX  :
                      (k_unpacked < -K_MAX) ? -K_MAX : k_unpacked;
    assign k_is_oob = (k_unpacked != regime_k);
    assign k        = regime_k;

    // Run plus terminator; the terminator may fall off the word at k = N-2.
    assign reg_len = regime_k[KW-1] ? RLW'(1 - int'(regime_k)) : RLW'(int'(regime_k) + 2);

    assign frac_len      = MLW'(N - 1 - ES - int'(reg_len));  // Negative eats into exponent.
    assign frac_len_diff = DW'(FFW - int'(frac_len));

    assign es_drop  = ES - max(0, min(ES, N - 1 - int'(reg_len)));
    assign next_exp = (exp_unpacked >> es_drop) << es_drop;  // Cleared low bits.

    assign frac                     = MW'(frac_full >> frac_len_diff);
    assign non_zero_frac_field_size = (frac_len >= 0);

    compute_rouding #(.N(N), .ES(ES)) compute_rouding_inst (
        .frac_len      (frac_len),
        .frac_full     (frac_full),
        .frac_len_diff (frac_len_diff),
        .k             (regime_k),
        .exp           (exp_unpacked),
        .frac_truncated(frac_truncated),
        .round_bit     (round_bit),
        .sticky_bit    (sticky_bit)
    );

endmodule

// File: posit_consts.svh
// Default posit sizes and the field widths derived from N and ES; include in every RTL file.
`ifndef POSIT_CONSTS_SVH
`define POSIT_CONSTS_SVH

`define POSIT_N  8
`define POSIT_ES 1

// The macros below expect module parameters N and ES in scope.
`define S              ($clog2(N))
`define MANT_SIZE      (N - ES - 3)
`define FRAC_FULL_SIZE (2 * `MANT_SIZE)
`define TE_SIZE        (`S + ES + 2)
`define K_SIZE         (`S + 2)
`define REG_LEN_SIZE   (`S + 2)
`define MANT_LEN_SIZE  (`S + 2)
`define EXP_SIZE       ((ES > 0) ? ES : 1)

`endif

// File: posit_decode.sv
// Posit decoder; turns one posit word into class, sign, scale and significand.
`timescale 1ns/10ps
`include "posit_consts.svh"

module posit_decode #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic [N-1:0]                word,
    output posit_fmt_pkg::posit_class_e cls,
    output logic                        sign,
    output logic signed [`TE_SIZE-1:0]  scale,
    output logic [`MANT_SIZE:0]         sig
);
    import posit_fmt_pkg::*;

    localparam int TEW = `TE_SIZE;
    localparam int MW  = `MANT_SIZE;
    localparam int EW  = `EXP_SIZE;

    logic [N-1:0]  mag;
    logic [N-2:0]  body;
    logic [N-2:0]  rest;
    logic [EW-1:0] exp_bits;
    logic          scan_done;
    int            run;
    int            k;

    assign sign = word[N-1];
    assign mag  = sign ? -word : word;  // Two's complement of negative words.
    assign body = mag[N-2:0];

    // Leading-bit scan of the regime run.
    always_comb begin
        run       = 0;
        scan_done = 1'b0;
        for (int i = N - 2; i >= 0; i--) begin
            if (!scan_done && body[i] == body[N-2]) begin
                run = run + 1;
            end else begin
                scan_done = 1'b1;
            end
        end
    end

    assign k        = body[N-2] ? run - 1 : -run;
    assign rest     = body << (run + 1);  // Cut exponent bits come in as zeros.
    assign exp_bits = rest[N-2 -: EW];
    assign scale    = TEW'(k * (2 ** ES) + ((ES > 0) ? int'(exp_bits) : 0));
    assign sig      = {1'b1, rest[N-2-ES -: MW]};

    always_comb begin
        if (word == '0) begin
            cls = PC_ZERO;
        end else if (word == {1'b1, {(N-1){1'b0}}}) begin
            cls = PC_NAR;
        end else begin
            cls = PC_NORMAL;
        end
    end

endmodule

// File: posit_encode.sv
// Consumer stage of the posit multiplier; assembles, rounds, signs and registers the result.
`timescale 1ns/10ps
`include "posit_consts.svh"

module posit_encode #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        stage_valid,
    input  logic                        sign,
    input  posit_fmt_pkg::posit_class_e res_class,
    input  logic signed [`K_SIZE-1:0]   k,
    input  logic [`EXP_SIZE-1:0]        next_exp,
    input  logic [`MANT_SIZE-1:0]       frac,
    input  logic                        round_bit,
    input  logic                        sticky_bit,
    input  logic                        k_is_oob,
    input  logic                        non_zero_frac_field_size,
    output logic                        out_valid,
    output logic [N-1:0]                p
);
    import posit_fmt_pkg::*;
    import posit_round_pkg::*;

    logic [N-2:0] body_reg;
    logic [N-2:0] body_exp;
    logic [N-2:0] body;
    logic [N-2:0] body_rnd;
    logic [N-1:0] word;
    logic [N-1:0] result;
    rnd_action_e  action;
    int           frac_len;

    always_comb begin
        if (k[$bits(k)-1]) begin
            body_reg = (N-1)'(1) << (N - 2 + int'(k));   // Zeros then a one.
            frac_len = N - 2 - ES + int'(k);
        end else begin
            body_reg = ~({(N-1){1'b1}} >> (int'(k) + 1));  // Ones then a zero.
            frac_len = N - 3 - ES - int'(k);
        end
        if (non_zero_frac_field_size) begin
            body_exp = (N-1)'(next_exp) << frac_len;
        end else begin
            body_exp = (N-1)'(next_exp) >> (-frac_len);
        end
    end

    assign body   = body_reg | body_exp | (N-1)'(frac);
    assign action = round_nearest_even(body[0], round_bit, sticky_bit);

    // Out of range saturates at maxpos or minpos.
    assign body_rnd = (action == RND_UP && !k_is_oob) ? body + 1'b1 : body;
    assign word     = sign ? -{1'b0, body_rnd} : {1'b0, body_rnd};

    always_comb begin
        case (res_class)
            PC_ZERO: result = '0;
            PC_NAR:  result = {1'b1, {(N-1){1'b0}}};
            default: result = word;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            p         <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                p <= result;
            end
        end
    end

    // Normal products never come out as zero or NaR.
    assert property (@(posedge clk) disable iff (!arst_n)
        stage_valid && res_class == PC_NORMAL |=> p != '0 && p != {1'b1, {(N-1){1'b0}}});

endmodule

// File: posit_fmt_pkg.sv
// Posit format types: operand class and integer helpers for field sizing.
package posit_fmt_pkg;

    typedef enum logic [1:0] {
        PC_ZERO   = 2'd0,   // All-zero word.
        PC_NAR    = 2'd1,   // Only the sign bit set.
        PC_NORMAL = 2'd2
    } posit_class_e;

    function automatic int min(input int x, input int y);
        return (x < y) ? x : y;
    endfunction

    function automatic int max(input int x, input int y);
        return (x > y) ? x : y;
    endfunction

endpackage

// File: posit_mul_checker.sv
// Testbench monitor; queues expected products and compares them with p when out_valid is seen.
`timescale 1ns/10ps
`include "posit_consts.svh"

module posit_mul_checker #(
    parameter int N = `POSIT_N
) (
    input  logic            clk,
    input  logic            out_valid,
    input  logic [N-1:0]    p,
    input  logic [N-1:0]    a,
    input  logic [N-1:0]    b,
    input  logic            exp_push,
    input  logic [N-1:0]    exp_word,
    input  logic [8*24-1:0] test_name,
    output int              pending,
    output int              checked,
    output int              errors
);
    localparam int LATENCY = 2;

    logic [N-1:0] exp_q[$];
    logic [N-1:0] a_q[$];
    logic [N-1:0] b_q[$];
    int           cyc_q[$];
    logic [N-1:0] want;
    logic [N-1:0] op_a;
    logic [N-1:0] op_b;
    int           issued;
    int           cyc       = 0;
    int           n_pending = 0;
    int           n_checked = 0;
    int           n_errors  = 0;

    assign pending = n_pending;
    assign checked = n_checked;
    assign errors  = n_errors;

    // Capture on rising edges, compare on falling edges.
    always @(posedge clk or negedge clk) begin
        if (clk) begin
            cyc = cyc + 1;
            if (exp_push) begin
                exp_q.push_back(exp_word);
                a_q.push_back(a);
                b_q.push_back(b);
                cyc_q.push_back(cyc);
            end
        end else if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: %0s: result %h arrived with no operation in flight",
                         test_name, p);
                n_errors++;
            end else begin
                want   = exp_q.pop_front();
                op_a   = a_q.pop_front();
                op_b   = b_q.pop_front();
                issued = cyc_q.pop_front();
                n_checked++;
                if (p !== want) begin
                    $display("CHECK FAILED %0s: a=%h b=%h expected=%h actual=%h",
                             test_name, op_a, op_b, want, p);
                    n_errors++;
                end
                if (cyc + 1 - issued != LATENCY) begin  // Seen at the next rising edge.
                    $display("ERROR: %0s: result came %0d cycles after its in_valid, not %0d",
                             test_name, cyc + 1 - issued, LATENCY);
                    n_errors++;
                end
            end
        end else if (exp_q.size() != 0 && cyc + 1 - cyc_q[0] >= LATENCY) begin
            $display("ERROR: %0s: no out_valid %0d cycles after in_valid for a=%h b=%h",
                     test_name, LATENCY, a_q[0], b_q[0]);
            n_errors++;
            void'(exp_q.pop_front());
            void'(a_q.pop_front());
            void'(b_q.pop_front());
            void'(cyc_q.pop_front());
        end
        n_pending = exp_q.size();
    end

endmodule

// File: posit_mul_core.sv
// Producer stage of the posit multiplier; decodes, multiplies and registers the raw product.
`timescale 1ns/10ps
`include "posit_consts.svh"

module posit_mul_core #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [N-1:0]                      a,
    input  logic [N-1:0]                      b,
    output logic                              stage_valid,
    output logic                              sign,
    output posit_fmt_pkg::posit_class_e       res_class,
    output logic [`FRAC_FULL_SIZE-1:0]        frac_full,
    output logic signed [`TE_SIZE-1:0]        total_exp,
    output logic                              frac_truncated
);
    import posit_fmt_pkg::*;

    localparam int FFW = `FRAC_FULL_SIZE;
    localparam int TEW = `TE_SIZE;
    localparam int MW  = `MANT_SIZE;

    posit_class_e          cls_a, cls_b, next_class;
    logic                  sign_a, sign_b;
    logic signed [TEW-1:0] scale_a, scale_b, exp_sum;
    logic [MW:0]           sig_a, sig_b;
    logic [FFW+1:0]        prod;
    logic                  prod_hi;
    logic [FFW-1:0]        frac_norm;

    posit_decode #(.N(N), .ES(ES)) dec_a (
        .word (a),
        .cls  (cls_a),
        .sign (sign_a),
        .scale(scale_a),
        .sig  (sig_a)
    );

    posit_decode #(.N(N), .ES(ES)) dec_b (
        .word (b),
        .cls  (cls_b),
        .sign (sign_b),
        .scale(scale_b),
        .sig  (sig_b)
    );

    assign prod      = sig_a * sig_b;
    assign prod_hi   = prod[FFW+1];  // Product at or above two.
    assign frac_norm = prod_hi ? prod[FFW:1] : prod[FFW-1:0];
    assign exp_sum   = scale_a + scale_b + TEW'(prod_hi);

    always_comb begin
        if (cls_a == PC_NAR || cls_b == PC_NAR) begin
            next_class = PC_NAR;
        end else if (cls_a == PC_ZERO || cls_b == PC_ZERO) begin
            next_class = PC_ZERO;
        end else begin
            next_class = PC_NORMAL;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sign           <= sign_a ^ sign_b;
            res_class      <= next_class;
            frac_full      <= frac_norm;
            total_exp      <= exp_sum;
            frac_truncated <= prod_hi & prod[0];  // Bit lost by normalizing.
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(stage_valid));

endmodule

// File: posit_mul_top.sv
// Top of the pipelined posit multiplier; producer stage, field packer and encoder stage.
`timescale 1ns/10ps
`include "posit_consts.svh"

module posit_mul_top #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         in_valid,
    input  logic [N-1:0] a,
    input  logic [N-1:0] b,
    output logic         out_valid,
    output logic [N-1:0] p
);
    import posit_fmt_pkg::*;

    logic                          stage_valid;
    logic                          sign;
    posit_class_e                  res_class;
    logic [`FRAC_FULL_SIZE-1:0]    frac_full;
    logic signed [`TE_SIZE-1:0]    total_exp;
    logic                          frac_truncated;
    logic signed [`K_SIZE-1:0]     k;
    logic [`EXP_SIZE-1:0]          next_exp;
    logic [`MANT_SIZE-1:0]         frac;
    logic                          round_bit;
    logic                          sticky_bit;
    logic                          k_is_oob;
    logic                          non_zero_frac_field_size;

    posit_mul_core #(.N(N), .ES(ES)) core_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .a             (a),
        .b             (b),
        .stage_valid   (stage_valid),
        .sign          (sign),
        .res_class     (res_class),
        .frac_full     (frac_full),
        .total_exp     (total_exp),
        .frac_truncated(frac_truncated)
    );

    pack_fields #(.N(N), .ES(ES)) pack_inst (
        .frac_full               (frac_full),
        .total_exp               (total_exp),
        .frac_truncated          (frac_truncated),
        .k                       (k),
        .next_exp                (next_exp),
        .frac                    (frac),
        .round_bit               (round_bit),
        .sticky_bit              (sticky_bit),
        .k_is_oob                (k_is_oob),
        .non_zero_frac_field_size(non_zero_frac_field_size)
    );

    posit_encode #(.N(N), .ES(ES)) encode_inst (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .stage_valid             (stage_valid),
        .sign                    (sign),
        .res_class               (res_class),
        .k                       (k),
        .next_exp                (next_exp),
        .frac                    (frac),
        .round_bit               (round_bit),
        .sticky_bit              (sticky_bit),
        .k_is_oob                (k_is_oob),
        .non_zero_frac_field_size(non_zero_frac_field_size),
        .out_valid               (out_valid),
        .p                       (p)
    );

endmodule

// File: posit_round_pkg.sv
// Rounding types and the nearest-even decision used by the posit encoder.
package posit_round_pkg;

    typedef enum logic {
        RND_KEEP = 1'b0,
        RND_UP   = 1'b1
    } rnd_action_e;

    // Ties go to the even neighbour.
    function automatic rnd_action_e round_nearest_even(
        input logic lsb,
        input logic round_bit,
        input logic sticky_bit
    );
        return (round_bit && (sticky_bit || lsb)) ? RND_UP : RND_KEEP;
    endfunction

endpackage

// File: tb.f
+incdir+.
posit_fmt_pkg.sv
posit_round_pkg.sv
posit_decode.sv
posit_mul_core.sv
unpack_exponent.sv
compute_rouding.sv
pack_fields.sv
posit_encode.sv
posit_mul_top.sv
posit_mul_checker.sv
tb_posit_mul.sv

// File: tb_posit_mul.sv
// Testbench for the posit multiplier; directed and LFSR operands checked against an exact model.
`timescale 1ns/10ps
`include "posit_consts.svh"

module tb_posit_mul #(
    parameter int          N    = `POSIT_N,
    parameter int          ES   = `POSIT_ES,
    parameter logic [31:0] SEED = 32'h29c5
);
    localparam int FW       = N;                // Fraction bits the model keeps per operand.
    localparam int BITS     = 4 * N + ES + 8;   // Longest unbounded bit string.
    localparam int TIMEOUT  = 100;
    localparam int N_RANDOM = 2000;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic [N-1:0]    a;
    logic [N-1:0]    b;
    logic            out_valid;
    logic [N-1:0]    p;
    logic            exp_push;
    logic [N-1:0]    exp_word;
    logic [8*24-1:0] test_name;
    int              pending;
    int              checked;
    int              errors;
    int              tb_errors;
    int              n_tests;
    int              test_checked;
    int              test_errors;
    logic [31:0]     lfsr;
    logic [N-1:0]    one;
    logic [N-1:0]    nar;
    logic [N-1:0]    maxpos;
    logic [N-1:0]    minpos;

    posit_mul_top #(.N(N), .ES(ES)) UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .p        (p)
    );

    posit_mul_checker #(.N(N)) checker_inst (
        .clk      (clk),
        .out_valid(out_valid),
        .p        (p),
        .a        (a),
        .b        (b),
        .exp_push (exp_push),
        .exp_word (exp_word),
        .test_name(test_name),
        .pending  (pending),
        .checked  (checked),
        .errors   (errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Right-shifting Galois form, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Returns {scale, significand}; the hidden one sits at bit FW.
    function automatic logic [95:0] decode_posit(input logic [N-1:0] w);
        logic [N-1:0] mag;
        logic         lead;
        logic         in_run;
        logic [63:0]  sig;
        int           run;
        int           pos;
        int           k;
        int           e;
        mag    = w[N-1] ? -w : w;
        lead   = mag[N-2];
        in_run = 1'b1;
        run    = 0;
        for (int i = N - 2; i >= 0; i--) begin
            if (in_run && mag[i] == lead) begin
                run++;
            end else begin
                in_run = 1'b0;
            end
        end
        k   = lead ? run - 1 : -run;
        pos = N - 3 - run;  // First bit after the terminator.
        e   = 0;
        for (int i = 0; i < ES; i++) begin
            e = 2 * e + (((pos >= 0) && mag[pos]) ? 1 : 0);
            pos--;
        end
        sig = 64'd1;
        for (int i = 0; i < FW; i++) begin
            sig = {sig[62:0], ((pos >= 0) && mag[pos])};
            pos--;
        end
        return {32'(k * (1 << ES) + e), sig};
    endfunction

    // Value 1.fr * 2^scale with fl fraction bits; returns {round, sticky, word}.
    function automatic logic [N+1:0] encode_exact(input logic sgn, input int scale,
                                                  input logic [63:0] fr, input int fl);
        logic [N-1:0] body;
        logic         bitv;
        logic         rb;
        logic         sticky;
        int           k;
        int           e;
        int           reg_len;
        int           len;
        k       = scale >>> ES;
        e       = scale - (k << ES);
        reg_len = (k >= 0) ? k + 2 : 1 - k;
        len     = reg_len + ES + fl;
        body    = '0;
        rb      = 1'b0;
        sticky  = 1'b0;
        for (int i = 0; i < BITS; i++) begin
            if (i >= len) begin
                bitv = 1'b0;
            end else if (i < reg_len - 1) begin
                bitv = (k >= 0);
            end else if (i == reg_len - 1) begin
                bitv = (k < 0);  // Terminator.
            end else if (i < reg_len + ES) begin
                bitv = e[ES - 1 - (i - reg_len)];
            end else begin
                bitv = fr[fl - 1 - (i - reg_len - ES)];
            end
            if (i < N - 1) begin
                body = {body[N-2:0], bitv};
            end else if (i == N - 1) begin
                rb = bitv;
            end else begin
                sticky = sticky | bitv;
            end
        end
        body = body + (rb & (sticky | body[0]));
        if (body[N-1]) begin
            body = {1'b0, {(N-1){1'b1}}};  // Clamp at maxpos.
        end else if (body == '0) begin
            body = 1;                      // Clamp at minpos.
        end
        if (sgn) begin
            body = -body;
        end
        return {rb, sticky, body};
    endfunction

    function automatic logic [N+1:0] multiply_exact(input logic [N-1:0] x,
                                                    input logic [N-1:0] y);
        logic [N-1:0] nar_word;
        logic [95:0]  dx;
        logic [95:0]  dy;
        logic [63:0]  prod;
        int           scale;
        int           fl;
        nar_word = {1'b1, {(N-1){1'b0}}};
        if (x == nar_word || y == nar_word) begin
            return {2'b00, nar_word};
        end
        if (x == '0 || y == '0) begin
            return '0;
        end
        dx    = decode_posit(x);
        dy    = decode_posit(y);
        prod  = dx[63:0] * dy[63:0];
        scale = int'(dx[95:64]) + int'(dy[95:64]);
        fl    = 2 * FW;
        if (prod[2*FW+1]) begin
            scale++;
            fl++;
        end
        return encode_exact(x[N-1] ^ y[N-1], scale, prod, fl);
    endfunction

    function automatic logic [N-1:0] pow2_word(input int s);
        logic [N+1:0] r;
        r = encode_exact(1'b0, s, 64'd0, 0);
        return r[N-1:0];
    endfunction

    task automatic send(input logic [N-1:0] x, input logic [N-1:0] y);
        logic [N+1:0] r;
        r = multiply_exact(x, y);
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        exp_push = 1'b1;
        exp_word = r[N-1:0];
    endtask

    task automatic idle();
        @(negedge clk);
        in_valid = 1'b0;
        exp_push = 1'b0;
    endtask

    task automatic start_test(input logic [8*24-1:0] name);
        test_name    = name;
        test_checked = checked;
        test_errors  = errors;
    endtask

    task automatic end_test();
        int waited;
        idle();
        waited = 0;
        while (pending != 0 && waited < TIMEOUT) begin
            @(posedge clk);  // Checker pops on falling edges.
            waited++;
        end
        if (pending != 0) begin
            $display("ERROR: %0s: %0d results still missing after %0d cycles",
                     test_name, pending, TIMEOUT);
            tb_errors++;
        end
        n_tests++;
        $display("%0s: %0d results checked, %0d errors", test_name,
                 checked - test_checked, errors - test_errors);
    endtask

    initial begin
        logic [31:0]  rv;
        logic [31:0]  rx;
        logic [N+1:0] r;
        logic [N-1:0] x;
        logic [N-1:0] y;
        int           sent;
        int           ties;
        int           ups;
        int           span;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        exp_push  = 1'b0;
        exp_word  = '0;
        test_name = "reset";
        lfsr      = SEED;
        tb_errors = 0;
        n_tests   = 0;
        one       = 1 << (N - 2);
        nar       = 1 << (N - 1);
        maxpos    = {1'b0, {(N-1){1'b1}}};
        minpos    = 1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("special_classes");
        send(nar, nar);
        send(nar, '0);
        send('0, nar);
        send(nar, one);
        send(-one, nar);
        send('0, '0);
        send('0, maxpos);
        send(minpos, '0);
        for (int i = 0; i < 4; i++) begin
            take_bits(N, rx);
            send(nar, rx[N-1:0]);
            send(rx[N-1:0], '0);
        end
        end_test();

        start_test("exact_products");
        for (int i = -3; i <= 3; i++) begin
            for (int j = -3; j <= 3; j++) begin
                send(pow2_word(i), pow2_word(j));
            end
        end
        for (int i = 0; i < 8; i++) begin
            take_bits(N, rx);
            send(one, rx[N-1:0]);
            send(-one, rx[N-1:0]);
            send(rx[N-1:0], one);
        end
        end_test();

        start_test("saturation");
        send(maxpos, maxpos);
        send(maxpos, pow2_word(2));
        send(minpos, minpos);
        send(minpos, pow2_word(-2));
        send(-maxpos, maxpos);
        send(-maxpos, -maxpos);
        send(minpos, -minpos);
        send(-minpos, minpos);
        send(maxpos, minpos);
        end_test();

        start_test("rounding");
        span = (N - ES - 3 > 5) ? 32 : (1 << (N - ES - 3));
        ties = 0;
        ups  = 0;
        for (int i = 0; i < span; i++) begin
            for (int j = 0; j < span; j++) begin
                x = one + i;
                y = one + j;
                r = multiply_exact(x, y);
                if (r[N+1] && !r[N] && ties < 12) begin
                    send(x, y);
                    send(-x, y);
                    ties++;
                end else if (r[N+1] && r[N] && ups < 12) begin
                    send(x, -y);
                    ups++;
                end
            end
        end
        if (ties == 0 || ups == 0) begin
            $display("ERROR: rounding: no tie or above-half operand pairs were found");
            tb_errors++;
        end
        end_test();

        start_test("random_stream");
        sent = 0;
        for (int c = 0; c < 20 * N_RANDOM && sent < N_RANDOM; c++) begin
            take_bits(1, rv);
            if (rv[0]) begin
                take_bits(N, rx);
                take_bits(N, rv);
                send(rx[N-1:0], rv[N-1:0]);
                sent++;
            end else begin
                idle();
            end
        end
        end_test();

        $display("Summary: %0d tests, %0d results checked, %0d errors",
                 n_tests, checked, errors + tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: unpack_exponent.sv
// Splits a signed total exponent into regime value and exponent field for the packer.
`timescale 1ns/10ps
`include "posit_consts.svh"

module unpack_exponent #(
    parameter int N  = `POSIT_N,
    parameter int ES = `POSIT_ES
) (
    input  logic signed [`TE_SIZE-1:0] total_exp,
    output logic signed [`K_SIZE-1:0]  k,
    output logic [`EXP_SIZE-1:0]       exp
);
    localparam int KW = `K_SIZE;
    localparam int EW = `EXP_SIZE;

    assign k = KW'(total_exp >>> ES);  // Floor division by 2^ES.

    generate
        if (ES > 0) begin : g_exp
            assign exp = total_exp[EW-1:0];
        end else begin : g_no_exp
            assign exp = '0;
        end
    endgenerate

endmodule
